/* hdl/dram_debug_pkg.sv */
package dram_debug_pkg;

    localparam int KNOB_W    = 10;  // one ADC knob reading
    localparam int SRC_W     = 3;   // one patch-source selection
    localparam int COUNT_W   = 24;  // completed-request counter
    localparam int DISPLAY_W = 32;  // eight hex digits

    // first field lands in the msbs
    typedef struct packed {
        logic [KNOB_W-1:0] volume;
        logic [KNOB_W-1:0] pitch;
        logic [KNOB_W-1:0] delay_wet;
        logic [KNOB_W-1:0] delay_rate;
        logic [KNOB_W-1:0] delay_feedback;
        logic [KNOB_W-1:0] reverb_wet;
        logic [KNOB_W-1:0] reverb_size;
        logic [KNOB_W-1:0] reverb_feedback;
        logic [KNOB_W-1:0] filter_quality;
        logic [KNOB_W-1:0] filter_cutoff;
        logic [KNOB_W-1:0] distortion_drive;
        logic [KNOB_W-1:0] crush_pressure;
    } knob_set_t;

    typedef struct packed {
        logic [SRC_W-1:0] output_src;
        logic [SRC_W-1:0] crush_src;
        logic [SRC_W-1:0] distortion_src;
        logic [SRC_W-1:0] filter_src;
        logic [SRC_W-1:0] reverb_src;
        logic [SRC_W-1:0] delay_src;
    } patch_src_t;

    // page select, comes straight off the switches
    typedef enum logic [2:0] {
        PAGE_REQ_COUNT            = 3'd0,
        PAGE_VOL_PITCH            = 3'd1,
        PAGE_DELAY_WET_RATE       = 3'd2,
        PAGE_DELAY_FB_REVERB_WET  = 3'd3,
        PAGE_REVERB_SIZE_FB       = 3'd4,
        PAGE_FILTER_Q_CUTOFF      = 3'd5,
        PAGE_DRIVE_CRUSH          = 3'd6,
        PAGE_PATCH_ROUTING        = 3'd7
    } display_page_e;

endpackage

/* hdl/seg_display_pkg.sv */
package seg_display_pkg;

    localparam int DIGITS   = 8;   // digits on the board, both halves together
    localparam int SEG_W    = 7;   // g..a, no decimal point
    localparam int SCAN_DIV = 16;  // clocks per digit

    localparam int SCAN_CNT_W = $clog2(SCAN_DIV);

    typedef logic [DIGITS-1:0]     seg_an_t;
    typedef logic [SEG_W-1:0]      seg_cat_t;
    typedef logic [SCAN_CNT_W-1:0] scan_cnt_t;

    // last count value before the divider wraps
    localparam scan_cnt_t SCAN_LAST = SCAN_CNT_W'(SCAN_DIV - 1);

    // one state per lit digit
    typedef enum logic [2:0] {
        SCAN_D0 = 3'd0,
        SCAN_D1 = 3'd1,
        SCAN_D2 = 3'd2,
        SCAN_D3 = 3'd3,
        SCAN_D4 = 3'd4,
        SCAN_D5 = 3'd5,
        SCAN_D6 = 3'd6,
        SCAN_D7 = 3'd7
    } scan_state_e;

endpackage

/* hdl/knob_sync.sv */
module knob_sync (
    input  logic                       clk_dram_ctrl,
    input  logic                       rst_dram_ctrl,
    input  dram_debug_pkg::knob_set_t  i_knobs,
    input  dram_debug_pkg::patch_src_t i_patch,
    output dram_debug_pkg::knob_set_t  o_knobs,
    output dram_debug_pkg::patch_src_t o_patch
);

    // first stage may go metastable, only the second is used
    dram_debug_pkg::knob_set_t  knobs_meta;
    dram_debug_pkg::patch_src_t patch_meta;

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            knobs_meta <= '0;
            patch_meta <= '0;
            o_knobs    <= '0;
            o_patch    <= '0;
        end else begin
            knobs_meta <= i_knobs;
            patch_meta <= i_patch;
            o_knobs    <= knobs_meta;
            o_patch    <= patch_meta;
        end
    end

endmodule

/* hdl/request_stats.sv */
module request_stats (
    input  logic                                clk_dram_ctrl,
    input  logic                                rst_dram_ctrl,
    input  logic                                i_mem_ack,     // one per finished request
    input  logic                                i_write_last,  // end of sample load
    output logic [dram_debug_pkg::COUNT_W-1:0] o_req_count,
    output logic                                o_write_done
);

    // counter rolls over at 2^24
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_req_count <= '0;
        end else if (i_mem_ack) begin
            o_req_count <= o_req_count + 1'b1;
        end
    end

    // sticky until reset
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_write_done <= 1'b0;
        end else if (i_write_last) begin
            o_write_done <= 1'b1;
        end
    end

endmodule

/* hdl/debug_page_mux.sv */
module debug_page_mux (
    input  dram_debug_pkg::display_page_e         i_page,
    input  dram_debug_pkg::knob_set_t             i_knobs,
    input  dram_debug_pkg::patch_src_t            i_patch,
    input  logic [dram_debug_pkg::COUNT_W-1:0]    i_req_count,
    output logic [dram_debug_pkg::DISPLAY_W-1:0]  o_word
);

    always_comb begin
        case (i_page)
            dram_debug_pkg::PAGE_VOL_PITCH:
                o_word = {16'(i_knobs.volume), 16'(i_knobs.pitch)};
            dram_debug_pkg::PAGE_DELAY_WET_RATE:
                o_word = {16'(i_knobs.delay_wet), 16'(i_knobs.delay_rate)};
            dram_debug_pkg::PAGE_DELAY_FB_REVERB_WET:
                o_word = {16'(i_knobs.delay_feedback), 16'(i_knobs.reverb_wet)};
            dram_debug_pkg::PAGE_REVERB_SIZE_FB:
                o_word = {16'(i_knobs.reverb_size), 16'(i_knobs.reverb_feedback)};
            dram_debug_pkg::PAGE_FILTER_Q_CUTOFF:
                o_word = {16'(i_knobs.filter_quality), 16'(i_knobs.filter_cutoff)};
            dram_debug_pkg::PAGE_DRIVE_CRUSH:
                o_word = {16'(i_knobs.distortion_drive), 16'(i_knobs.crush_pressure)};
            dram_debug_pkg::PAGE_PATCH_ROUTING: begin
                // one source per digit, delay leftmost
                o_word = {8'h00,
                          1'b0, i_patch.delay_src,
                          1'b0, i_patch.reverb_src,
                          1'b0, i_patch.filter_src,
                          1'b0, i_patch.distortion_src,
                          1'b0, i_patch.crush_src,
                          1'b0, i_patch.output_src};
            end
            default:
                o_word = {16'h0000, i_req_count[15:0]};  // low half of the count only
        endcase
    end

endmodule

/* hdl/scan_timer.sv */
module scan_timer (
    input  logic clk_dram_ctrl,
    input  logic rst_dram_ctrl,
    output logic o_tick
);

    seg_display_pkg::scan_cnt_t div_cnt;

    // free running, wraps every SCAN_DIV clocks
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            div_cnt <= '0;
        end else if (div_cnt == seg_display_pkg::SCAN_LAST) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign o_tick = (div_cnt == seg_display_pkg::SCAN_LAST);  // wrap cycle

endmodule

/* hdl/digit_scan_fsm.sv */
module digit_scan_fsm (
    input  logic                         clk_dram_ctrl,
    input  logic                         rst_dram_ctrl,
    input  logic                         i_tick,
    output seg_display_pkg::scan_state_e o_state
);

    seg_display_pkg::scan_state_e state_next;

    // ring D0 -> D7 -> D0
    always_comb begin
        case (o_state)
            seg_display_pkg::SCAN_D0: state_next = seg_display_pkg::SCAN_D1;
            seg_display_pkg::SCAN_D1: state_next = seg_display_pkg::SCAN_D2;
            seg_display_pkg::SCAN_D2: state_next = seg_display_pkg::SCAN_D3;
            seg_display_pkg::SCAN_D3: state_next = seg_display_pkg::SCAN_D4;
            seg_display_pkg::SCAN_D4: state_next = seg_display_pkg::SCAN_D5;
            seg_display_pkg::SCAN_D5: state_next = seg_display_pkg::SCAN_D6;
            seg_display_pkg::SCAN_D6: state_next = seg_display_pkg::SCAN_D7;
            default:                  state_next = seg_display_pkg::SCAN_D0;
        endcase
    end

    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_state <= seg_display_pkg::SCAN_D0;
        end else if (i_tick) begin
            o_state <= state_next;  // hold between ticks
        end
    end

endmodule

/* hdl/segment_driver.sv */
module segment_driver (
    input  logic                                 clk_dram_ctrl,
    input  logic                                 rst_dram_ctrl,
    input  seg_display_pkg::scan_state_e         i_state,
    input  logic [dram_debug_pkg::DISPLAY_W-1:0] i_word,
    output seg_display_pkg::seg_an_t             o_seg_an,
    output seg_display_pkg::seg_cat_t            o_seg_cat
);

    logic [3:0]                nibble;
    seg_display_pkg::seg_cat_t cat_next;
    seg_display_pkg::seg_an_t  an_next;

    assign nibble  = i_word[{i_state, 2'b00} +: 4];  // nibble 0 is the lsb digit
    assign an_next = ~(seg_display_pkg::seg_an_t'(1) << i_state);

    // gfedcba, low lights the segment
    always_comb begin
        case (nibble)
            4'h0: cat_next = 7'b1000000;
            4'h1: cat_next = 7'b1111001;
            4'h2: cat_next = 7'b0100100;
            4'h3: cat_next = 7'b0110000;
            4'h4: cat_next = 7'b0011001;
            4'h5: cat_next = 7'b0010010;
            4'h6: cat_next = 7'b0000010;
            4'h7: cat_next = 7'b1111000;
            4'h8: cat_next = 7'b0000000;
            4'h9: cat_next = 7'b0010000;
            4'ha: cat_next = 7'b0001000;
            4'hb: cat_next = 7'b0000011;  // lower case b
            4'hc: cat_next = 7'b1000110;
            4'hd: cat_next = 7'b0100001;  // lower case d
            4'he: cat_next = 7'b0000110;
            default: cat_next = 7'b0001110;
        endcase
    end

    // anode and cathode move together so no ghosting on the next digit
    always_ff @(posedge clk_dram_ctrl) begin
        if (rst_dram_ctrl) begin
            o_seg_an  <= '1;
            o_seg_cat <= '1;
        end else begin
            o_seg_an  <= an_next;
            o_seg_cat <= cat_next;
        end
    end

endmodule

/* hdl/dram_debug_display.sv */
module dram_debug_display (
    input  logic                                clk_dram_ctrl,
    input  logic                                rst_dram_ctrl,
    input  logic                                i_mem_ack,
    input  logic                                i_write_last,
    input  dram_debug_pkg::knob_set_t           i_knobs,
    input  dram_debug_pkg::patch_src_t          i_patch,
    input  dram_debug_pkg::display_page_e       i_page,
    output logic [dram_debug_pkg::COUNT_W-1:0] o_req_count,
    output logic                                o_write_done,
    output seg_display_pkg::seg_an_t            o_seg_an,
    output seg_display_pkg::seg_cat_t           o_seg_cat
);

    dram_debug_pkg::knob_set_t            knobs_sync;
    dram_debug_pkg::patch_src_t           patch_sync;
    logic [dram_debug_pkg::DISPLAY_W-1:0] disp_word;
    logic                                 scan_tick;
    seg_display_pkg::scan_state_e         scan_state;

    knob_sync u_knob_sync (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_knobs       (i_knobs),
        .i_patch       (i_patch),
        .o_knobs       (knobs_sync),
        .o_patch       (patch_sync)
    );

    request_stats u_request_stats (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_mem_ack     (i_mem_ack),
        .i_write_last  (i_write_last),
        .o_req_count   (o_req_count),
        .o_write_done  (o_write_done)
    );

    // page select is static from the switches, no sync stage
    debug_page_mux u_debug_page_mux (
        .i_page      (i_page),
        .i_knobs     (knobs_sync),
        .i_patch     (patch_sync),
        .i_req_count (o_req_count),
        .o_word      (disp_word)
    );

    scan_timer u_scan_timer (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .o_tick        (scan_tick)
    );

    digit_scan_fsm u_digit_scan_fsm (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_tick        (scan_tick),
        .o_state       (scan_state)
    );

    segment_driver u_segment_driver (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_state       (scan_state),
        .i_word        (disp_word),
        .o_seg_an      (o_seg_an),
        .o_seg_cat     (o_seg_cat)
    );

endmodule

/* sim/tb_clock.sv */
module tb_clock (
    output logic clk_dram_ctrl,
    output logic rst_dram_ctrl
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 20;  // 40 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_dram_ctrl = 1'b0;
        forever #HALF_PERIOD clk_dram_ctrl = ~clk_dram_ctrl;
    end

    // released on a rising edge like the rest of the stimulus
    initial begin
        rst_dram_ctrl = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_dram_ctrl);
        rst_dram_ctrl <= 1'b0;
    end

endmodule

/* sim/dram_debug_properties.sv */
module dram_debug_properties (
    input logic                         clk_dram_ctrl,
    input logic                         rst_dram_ctrl,
    input logic                         i_tick,
    input seg_display_pkg::scan_state_e i_state,
    input seg_display_pkg::seg_an_t     i_seg_an,
    input seg_display_pkg::seg_cat_t    i_seg_cat
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;  // assertion failures so far

    // display stays dark while held in reset
    a_dark_in_reset: assert property (@(posedge clk_dram_ctrl)
        rst_dram_ctrl |=> (!rst_dram_ctrl || (&i_seg_an && &i_seg_cat)))
        else begin
            fail_count++;
            $error("display lit during reset");
        end

    a_dark_after_reset: assert property (@(posedge clk_dram_ctrl)
        $fell(rst_dram_ctrl) |-> (&i_seg_an && &i_seg_cat))
        else begin
            fail_count++;
            $error("display lit in first cycle after reset");
        end

    a_one_digit: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        !$past(rst_dram_ctrl) |-> $onehot(~i_seg_an))
        else begin
            fail_count++;
            $error("anode not one-cold");
        end

    // scan state only moves on the cycle after a tick
    a_state_on_tick: assert property (@(posedge clk_dram_ctrl) disable iff (rst_dram_ctrl)
        (!$past(i_tick) && !$past(rst_dram_ctrl)) |-> $stable(i_state))
        else begin
            fail_count++;
            $error("scan state moved without a tick");
        end

endmodule

bind dram_debug_display dram_debug_properties u_props (
    .clk_dram_ctrl (clk_dram_ctrl),
    .rst_dram_ctrl (rst_dram_ctrl),
    .i_tick        (scan_tick),
    .i_state       (scan_state),
    .i_seg_an      (o_seg_an),
    .i_seg_cat     (o_seg_cat)
);

/* sim/dram_debug_display_tb.sv */
module dram_debug_display_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCAN_CYCLES = seg_display_pkg::DIGITS * seg_display_pkg::SCAN_DIV;
    localparam int SETTLE      = 2 + SCAN_CYCLES + 1;  // sync + full scan + output reg
    localparam int DISP_CYCLES = 1 + SETTLE + SCAN_CYCLES;
    localparam int REQ_CYCLES  = 400;
    localparam int WR_CYCLES   = 200;
    localparam int KNOB_SETS   = 2;
    localparam int PATCH_SETS  = 3;
    localparam int COUNT_ACKS  = 37;
    localparam int TOTAL       = 8 + REQ_CYCLES + WR_CYCLES + COUNT_ACKS + 2 * SCAN_CYCLES
                               + (6 * KNOB_SETS + PATCH_SETS + 1) * DISP_CYCLES;
    localparam int TIMEOUT_NS  = (TOTAL + 200) * 40;

    logic                          clk_dram_ctrl;
    logic                          rst_dram_ctrl;
    logic                          mem_ack;
    logic                          write_last;
    dram_debug_pkg::knob_set_t     knobs;
    dram_debug_pkg::patch_src_t    patch;
    dram_debug_pkg::display_page_e page;
    logic [23:0]                   req_count;
    logic                          write_done;
    seg_display_pkg::seg_an_t      seg_an;
    seg_display_pkg::seg_cat_t     seg_cat;

    logic [31:0] rng;
    logic [23:0] model_count;
    logic        model_done;
    int          err_count, err_mark, check_count, tests_run, tests_failed;

    tb_clock u_clock (.clk_dram_ctrl(clk_dram_ctrl), .rst_dram_ctrl(rst_dram_ctrl));

    dram_debug_display UUT (
        .clk_dram_ctrl (clk_dram_ctrl),
        .rst_dram_ctrl (rst_dram_ctrl),
        .i_mem_ack     (mem_ack),
        .i_write_last  (write_last),
        .i_knobs       (knobs),
        .i_patch       (patch),
        .i_page        (page),
        .o_req_count   (req_count),
        .o_write_done  (write_done),
        .o_seg_an      (seg_an),
        .o_seg_cat     (seg_cat)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // lit segments as gfedcba, 1 = on, then inverted for the active-low bus
    function automatic logic [6:0] glyph(input logic [3:0] n);
        logic [6:0] lit [16] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
                                 7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71};
        return ~lit[n];
    endfunction

    function automatic int lit_digit(input logic [7:0] an);
        int idx;
        idx = -1;
        for (int k = 0; k < 8; k++) begin
            if (an[k] === 1'b0) idx = (idx == -1) ? k : -2;
        end
        return (idx < 0) ? -1 : idx;
    endfunction

    // knob k sits at bits 119-10k; page p shows knobs 2p-2 and 2p-1
    function automatic logic [31:0] expected_word(input logic [2:0] pg, input logic [119:0] kv,
                                                  input logic [17:0] sv, input logic [23:0] cnt);
        logic [31:0] w;
        w = {16'h0000, cnt[15:0]};
        if (pg >= 3'd1 && pg <= 3'd6) begin
            w = {6'b0, kv[119 - 20 * (pg - 1) -: 10], 6'b0, kv[109 - 20 * (pg - 1) -: 10]};
        end else if (pg == 3'd7) begin
            w = '0;
            for (int j = 0; j < 6; j++) w[4 * j +: 4] = {1'b0, sv[17 - 3 * j -: 3]};
        end
        return w;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng = xorshift32(rng);
        v   = rng;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_count == err_mark) begin
            $display("test %-22s ok", name);
        end else begin
            tests_failed++;
            $display("test %-22s failed with %0d errors", name, err_count - err_mark);
        end
        err_mark = err_count;
    endtask

    // wait out the display latency, then look at every lit digit for one scan
    task automatic scan_and_check(input logic [31:0] word);
        int idx;
        repeat (SETTLE) @(posedge clk_dram_ctrl);
        repeat (SCAN_CYCLES) begin
            @(negedge clk_dram_ctrl);
            idx = lit_digit(seg_an);
            if (idx < 0) begin
                err_count++;
                $display("anode pattern %b does not light exactly one digit", seg_an);
            end else begin
                check_value($sformatf("o_seg_cat digit %0d", idx), seg_cat,
                            glyph(word[4 * idx +: 4]));
            end
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [31:0]                r;
        logic [127:0]               kr;
        dram_debug_pkg::knob_set_t  kv;
        dram_debug_pkg::patch_src_t pv;
        logic                       pend;
        int                         prev, cur, wraps;
        mem_ack = 1'b0;
        write_last = 1'b0;
        knobs = '0;
        patch = '0;
        page = dram_debug_pkg::PAGE_REQ_COUNT;
        rng = 32'h69a7_f31f;
        {model_count, model_done, pv, kr} = '0;
        {err_count, err_mark, check_count, tests_run, tests_failed} = '0;

        @(negedge rst_dram_ctrl);
        @(negedge clk_dram_ctrl);
        check_value("o_req_count", req_count, 0);
        check_value("o_write_done", write_done, 0);
        check_value("o_seg_an", seg_an, 8'hff);
        check_value("o_seg_cat", seg_cat, 7'h7f);
        finish_test("reset values");

        pend = 1'b0;
        for (int i = 0; i <= REQ_CYCLES; i++) begin
            next_rand(r);
            @(posedge clk_dram_ctrl);
            mem_ack <= (i < REQ_CYCLES) && r[0];
            model_count += pend;  // strobe from last cycle counted on this edge
            pend = (i < REQ_CYCLES) && r[0];
            @(negedge clk_dram_ctrl);
            check_value("o_req_count", req_count, model_count);
        end
        finish_test("request counting");

        pend = 1'b0;
        for (int i = 0; i <= WR_CYCLES; i++) begin
            next_rand(r);
            @(posedge clk_dram_ctrl);
            write_last <= (i < WR_CYCLES) && (r[3:0] == 4'h0 || i == WR_CYCLES / 2);
            model_done |= pend;
            pend = (i < WR_CYCLES) && (r[3:0] == 4'h0 || i == WR_CYCLES / 2);
            @(negedge clk_dram_ctrl);
            check_value("o_write_done", write_done, model_done);
        end
        finish_test("write-done latch");

        for (int p = 1; p <= 6; p++) begin
            for (int n = 0; n < KNOB_SETS; n++) begin
                for (int i = 0; i < 4; i++) begin
                    next_rand(r);
                    kr = {kr[95:0], r};
                end
                kv = kr[119:0];
                @(posedge clk_dram_ctrl);
                knobs <= kv;
                page  <= dram_debug_pkg::display_page_e'(p);
                scan_and_check(expected_word(3'(p), kv, pv, model_count));
            end
        end
        finish_test("knob pages");

        for (int n = 0; n < PATCH_SETS; n++) begin
            next_rand(r);
            pv = r[17:0];
            @(posedge clk_dram_ctrl);
            patch <= pv;
            page  <= dram_debug_pkg::PAGE_PATCH_ROUTING;
            scan_and_check(expected_word(3'd7, kv, pv, model_count));
        end
        @(posedge clk_dram_ctrl);
        page <= dram_debug_pkg::PAGE_REQ_COUNT;
        repeat (COUNT_ACKS) begin
            @(posedge clk_dram_ctrl);
            mem_ack <= 1'b1;
        end
        @(posedge clk_dram_ctrl);
        mem_ack <= 1'b0;
        model_count += COUNT_ACKS;
        scan_and_check(expected_word(3'd0, kv, pv, model_count));
        finish_test("patch and count pages");

        // lit digit must step 0,1,..,7,0 at every anode change
        @(negedge clk_dram_ctrl);
        prev = lit_digit(seg_an);
        wraps = 0;
        repeat (2 * SCAN_CYCLES) begin
            @(negedge clk_dram_ctrl);
            cur = lit_digit(seg_an);
            if (cur != prev) begin
                check_value("lit digit index", cur, (prev + 1) % 8);
                if (prev == 7) wraps++;
            end
            prev = cur;
        end
        if (wraps < 2) begin
            err_count++;
            $display("scan did not wrap from digit 7 to digit 0 twice in two scans");
        end
        finish_test("scan order");

        if (UUT.u_props.fail_count != 0) begin
            err_count += UUT.u_props.fail_count;
            $display("bound assertions failed %0d times", UUT.u_props.fail_count);
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* dram_debug_display.f */
hdl/dram_debug_pkg.sv
hdl/seg_display_pkg.sv
hdl/knob_sync.sv
hdl/request_stats.sv
hdl/debug_page_mux.sv
hdl/scan_timer.sv
hdl/digit_scan_fsm.sv
hdl/segment_driver.sv
hdl/dram_debug_display.sv
sim/tb_clock.sv
sim/dram_debug_properties.sv
sim/dram_debug_display_tb.sv

/* Bender.yml */
package:
  name: dram_debug_display

sources:
  - files:
      - hdl/dram_debug_pkg.sv
      - hdl/seg_display_pkg.sv
      - hdl/knob_sync.sv
      - hdl/request_stats.sv
      - hdl/debug_page_mux.sv
      - hdl/scan_timer.sv
      - hdl/digit_scan_fsm.sv
      - hdl/segment_driver.sv
      - hdl/dram_debug_display.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/dram_debug_properties.sv
      - sim/dram_debug_display_tb.sv
